// ==== Makefile ====
# Verilator build and run of the address generation stage testbench

VERILATOR ?= verilator
TOP       ?= agu_tb
FILELIST  ?= agu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check

# Verdict comes from the log
check:
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "No verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== agu_top.f ====
hw/agu_pkg.sv
hw/spill_cell_flush.sv
hw/address_adder.sv
hw/agu_ans_arbiter.sv
hw/agu_top.sv
bench/agu_asserts.sv
bench/agu_tb.sv

// ==== bench/agu_asserts.sv ====
// Concurrent checks on the top-level handshake and flush behaviour
// Bound into agu_top, so port names follow the top-level signals
`timescale 1ns/100ps

module agu_asserts
  import agu_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     flush_i,
  input logic     ld_ready_o,
  input logic     st_ready_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input agu_out_t out_o
);

  // --------------------
  // Output handshake
  // --------------------
  // A stalled record stays put until taken or flushed
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(out_o)))
    else $error("out_o changed while stalled");

  // --------------------
  // Flush and reset
  // --------------------
  a_flush_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> (!ld_ready_o && !st_ready_o))
    else $error("request port ready during flush");

  a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o)
    else $error("output valid right after flush");

  // Cells start empty
  a_reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("output valid after reset");

endmodule

bind agu_top agu_asserts u_asserts (.*);

// ==== bench/agu_tb.sv ====
// Latency and contention phases first, then seeded random traffic with flushes
// Expected answers are kept in one queue per stream
// Alternation is only checked while both streams are kept busy
`timescale 1ns/100ps

module agu_tb
  import agu_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int DRIVE_DELAY    = 2;
  localparam int RESET_CYCLES   = 16;
  localparam int LAT_REQS       = 8;
  localparam int CONTEND_CYCLES = 40;
  localparam int DIRECTED_CYCLES = 200;
  localparam int RAND_CYCLES    = 4000;
  localparam int DRAIN_CYCLES   = 200;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES
                                  + DRAIN_CYCLES + 100;

  logic       clk_i;
  logic       rst_n_i;
  logic       flush_i;
  logic       ld_valid_i;
  logic       ld_ready_o;
  adder_req_t ld_req_i;
  logic       st_valid_i;
  logic       st_ready_o;
  adder_req_t st_req_i;
  logic       out_valid_o;
  logic       out_ready_i;
  agu_out_t   out_o;

  integer     seed = 32'h462e;
  int         err_value = 0;
  int         err_other = 0;
  int         cycle_cnt = 0;
  bit         check_latency = 1'b0;
  bit         check_alternation = 1'b0;
  // Reset pointer favours loads as if a store had won last
  bit         last_is_store = 1'b1;
  adder_ans_t ld_exp_q[$];
  adder_ans_t st_exp_q[$];
  int         ld_cyc_q[$];
  int         st_cyc_q[$];

  agu_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic adder_ans_t expect_answer(adder_req_t req, bit is_store);
    adder_ans_t      a;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] size;
    addr = req.base + req.offs;
    case (req.ls_type)
      LS_HALFWORD, LS_HALFWORD_U: size = 64'd2;
      LS_WORD, LS_WORD_U:         size = 64'd4;
      LS_DOUBLEWORD:              size = 64'd8;
      default:                    size = 64'd1;
    endcase
    a.tag           = req.tag;
    a.result        = addr;
    a.except_raised = ((addr % size) != '0);
    // Misaligned store is code 6 and misaligned load code 4
    a.except_code   = is_store ? 5'd6 : 5'd4;
    return a;
  endfunction

  function automatic bit chance(int unsigned num, int unsigned den);
    return ($unsigned($random(seed)) % den) < num;
  endfunction

  function automatic adder_req_t random_request();
    adder_req_t r;
    r.tag     = 4'($random(seed));
    r.ls_type = ls_type_t'(3'($unsigned($random(seed)) % 7));
    r.base    = {32'($random(seed)), 32'($random(seed))};
    r.offs    = 64'($signed(12'($random(seed))));
    case (2'($random(seed)))
      // Negative offset wraps a small base below zero
      2'd1: begin
        r.base[XLEN-1:8] = '0;
        r.offs = -64'($unsigned(12'($random(seed)))) - 64'd1;
      end
      // Positive offset wraps a base near the top past it
      2'd2: begin
        r.base[XLEN-1:8] = '1;
        r.offs = 64'($unsigned(12'($random(seed))));
      end
      2'd3: r.offs = {32'($random(seed)), 32'($random(seed))};
      default: ;
    endcase
    // Half of the sums land on an 8-byte boundary
    if (chance(1, 2)) begin
      r.base[2:0] = 3'b000;
      r.offs[2:0] = 3'b000;
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp_val);
    if (got !== exp_val) begin
      err_value++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp_val);
    end
  endtask

  task automatic compare_output();
    adder_ans_t expd;
    int         acc;
    if (check_alternation) begin
      check_value("out_o.is_store", 64'(out_o.is_store), 64'(!last_is_store));
    end
    last_is_store = out_o.is_store;
    if ((out_o.is_store ? st_exp_q.size() : ld_exp_q.size()) == 0) begin
      err_other++;
      $display("Answer at %0t has no outstanding request on its stream", $time);
      return;
    end
    if (out_o.is_store) begin
      expd = st_exp_q.pop_front();
      acc  = st_cyc_q.pop_front();
    end else begin
      expd = ld_exp_q.pop_front();
      acc  = ld_cyc_q.pop_front();
    end
    check_value("out_o.ans.tag", 64'(out_o.ans.tag), 64'(expd.tag));
    check_value("out_o.ans.result", out_o.ans.result, expd.result);
    check_value("out_o.ans.except_raised", 64'(out_o.ans.except_raised),
                64'(expd.except_raised));
    check_value("out_o.ans.except_code", 64'(out_o.ans.except_code), 64'(expd.except_code));
    if (check_latency) begin
      check_value("out_valid_o latency", 64'(cycle_cnt - acc), 64'd2);
    end
  endtask

  // Samples every handshake at the edge before the DUT registers update
  always @(posedge clk_i) begin
    if (rst_n_i && flush_i) begin
      ld_exp_q.delete();
      st_exp_q.delete();
      ld_cyc_q.delete();
      st_cyc_q.delete();
    end else if (rst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        compare_output();
      end
      if (ld_valid_i && ld_ready_o) begin
        ld_exp_q.push_back(expect_answer(ld_req_i, 1'b0));
        ld_cyc_q.push_back(cycle_cnt);
      end
      if (st_valid_i && st_ready_o) begin
        st_exp_q.push_back(expect_answer(st_req_i, 1'b1));
        st_cyc_q.push_back(cycle_cnt);
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic wait_empty(int limit);
    int n;
    n = 0;
    while ((ld_exp_q.size() != 0 || st_exp_q.size() != 0) && n < limit) begin
      @(posedge clk_i);
      n++;
    end
  endtask

  // One request at a time on alternating streams
  task automatic measure_latency();
    bit is_store;
    check_latency = 1'b1;
    for (int i = 0; i < LAT_REQS; i++) begin
      is_store = (i % 2 == 1);
      @(posedge clk_i);
      #DRIVE_DELAY;
      ld_valid_i = !is_store;
      st_valid_i = is_store;
      ld_req_i   = random_request();
      st_req_i   = random_request();
      @(posedge clk_i);
      while (!(is_store ? st_ready_o : ld_ready_o)) begin
        @(posedge clk_i);
      end
      #DRIVE_DELAY;
      ld_valid_i = 1'b0;
      st_valid_i = 1'b0;
      wait_empty(DRAIN_CYCLES);
    end
    check_latency = 1'b0;
  endtask

  // Both streams busy with the output always ready
  task automatic contend_both_streams();
    check_alternation = 1'b1;
    for (int i = 0; i < CONTEND_CYCLES; i++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      ld_valid_i = 1'b1;
      st_valid_i = 1'b1;
      ld_req_i   = random_request();
      st_req_i   = random_request();
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_alternation = 1'b0;
    ld_valid_i = 1'b0;
    st_valid_i = 1'b0;
    wait_empty(DRAIN_CYCLES);
  endtask

  task automatic random_traffic();
    int hold;
    hold = 0;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      ld_valid_i = chance(5, 8);
      st_valid_i = chance(5, 8);
      ld_req_i   = random_request();
      st_req_i   = random_request();
      // Occasional stretches of back-pressure
      if (hold > 0) begin
        out_ready_i = 1'b0;
        hold--;
      end else if (chance(1, 40)) begin
        out_ready_i = 1'b0;
        hold = 2 + int'($unsigned($random(seed)) % 12);
      end else begin
        out_ready_i = chance(3, 4);
      end
      // Single-cycle flush pulses
      flush_i = !flush_i && chance(1, 150);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    flush_i     = 1'b0;
    ld_valid_i  = 1'b0;
    st_valid_i  = 1'b0;
    out_ready_i = 1'b1;
  endtask

  initial begin
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    ld_valid_i  = 1'b0;
    st_valid_i  = 1'b0;
    ld_req_i    = '0;
    st_req_i    = '0;
    out_ready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i     = 1'b1;
    out_ready_i = 1'b1;
    measure_latency();
    contend_both_streams();
    random_traffic();
    wait_empty(DRAIN_CYCLES);
    if (ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
      err_other++;
      $display("Answers never arrived: %0d loads and %0d stores still expected",
               ld_exp_q.size(), st_exp_q.size());
    end
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== hw/address_adder.sv ====
// Base plus offset adder with natural alignment check
// No virtual memory; the sum wraps modulo 2^XLEN
// Answer is registered through a spill cell, one cycle after acceptance
`timescale 1ns/100ps

module address_adder
  import agu_pkg::*;
#(
  parameter bit IS_STORE = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,

  // Request side
  input  logic       valid_i,
  output logic       ready_o,
  input  adder_req_t req_i,

  // Answer side
  output logic       valid_o,
  input  logic       ready_i,
  output adder_ans_t ans_o
);

  // --------------------
  // Internal signals
  // --------------------
  logic [XLEN-1:0] sum;
  logic            misaligned;
  adder_ans_t      ans;

  // Effective address
  assign sum = req_i.base + req_i.offs;

  // --------------------
  // Alignment check
  // --------------------
  always_comb begin
    // Low address bits must be zero for the access size
    case (req_i.ls_type)
      LS_HALFWORD, LS_HALFWORD_U: misaligned = sum[0];
      LS_WORD, LS_WORD_U:         misaligned = |sum[1:0];
      LS_DOUBLEWORD:              misaligned = |sum[2:0];
      // Byte accesses are always aligned
      default:                    misaligned = 1'b0;
    endcase
  end

  // Answer record
  assign ans.tag           = req_i.tag;
  assign ans.result        = sum;
  assign ans.except_raised = misaligned;
  // Code depends only on the stream, not on the check result
  assign ans.except_code   = IS_STORE ? E_ST_ADDR_MISALIGNED : E_LD_ADDR_MISALIGNED;

  // --------------------
  // Output register
  // --------------------
  spill_cell_flush #(
    .DATA_T(adder_ans_t)
  ) u_ans_cell (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .data_i (ans),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .data_o (ans_o)
  );

endmodule

// ==== hw/agu_ans_arbiter.sv ====
// Round-robin merge of load and store answers into one stream
// Grant is combinational; the merged record is registered in a spill cell
// Pointer favours loads after reset and only moves on an accepted grant
`timescale 1ns/100ps

module agu_ans_arbiter
  import agu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,

  // Load answers
  input  logic       ld_valid_i,
  output logic       ld_ready_o,
  input  adder_ans_t ld_ans_i,

  // Store answers
  input  logic       st_valid_i,
  output logic       st_ready_o,
  input  adder_ans_t st_ans_i,

  // Merged output
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output agu_out_t   out_o
);

  // --------------------
  // Internal signals
  // --------------------
  // Set when the store side has priority on a tie
  logic     prio_st;
  logic     grant_ld;
  logic     grant_st;
  logic     cell_ready;
  agu_out_t merged;

  // One side per cycle; a lone request always wins
  assign grant_ld = ld_valid_i & (~st_valid_i | ~prio_st);
  assign grant_st = st_valid_i & (~ld_valid_i | prio_st);

  // Ready goes back only to the granted side
  assign ld_ready_o = grant_ld & cell_ready;
  assign st_ready_o = grant_st & cell_ready;

  // Tag the winner with its stream
  assign merged.is_store = grant_st;
  assign merged.ans      = grant_st ? st_ans_i : ld_ans_i;

  // --------------------
  // Priority pointer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_st <= 1'b0;
    end else if (cell_ready && (grant_ld || grant_st)) begin
      // Loser of this grant is favoured next time
      prio_st <= grant_ld;
    end
  end

  // --------------------
  // Output register
  // --------------------
  spill_cell_flush #(
    .DATA_T(agu_out_t)
  ) u_out_cell (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(ld_valid_i | st_valid_i),
    .ready_o(cell_ready),
    .data_i (merged),
    .valid_o(out_valid_o),
    .ready_i(out_ready_i),
    .data_o (out_o)
  );

endmodule

// ==== hw/agu_pkg.sv ====
// Shared widths, encodings and records of the address generation stage
// Physical addresses only, no translation and no TLB
// Exception codes follow the RISC-V mcause numbering for misaligned accesses
package agu_pkg;

  // --------------------
  // Widths
  // --------------------

  // Data and address width
  localparam int unsigned XLEN = 64;

  // Instruction tag used to match answers with their requests
  localparam int unsigned TAG_W = 4;

  // Exception code width
  localparam int unsigned EXC_W = 5;

  // --------------------
  // Exception codes
  // --------------------

  // Load address misaligned
  localparam logic [EXC_W-1:0] E_LD_ADDR_MISALIGNED = 5'd4;

  // Store/AMO address misaligned
  localparam logic [EXC_W-1:0] E_ST_ADDR_MISALIGNED = 5'd6;

  // --------------------
  // Access sizes
  // --------------------

  // Signed and unsigned variants share the same alignment rule
  typedef enum logic [2:0] {
    LS_BYTE       = 3'd0,
    LS_BYTE_U     = 3'd1,
    LS_HALFWORD   = 3'd2,
    LS_HALFWORD_U = 3'd3,
    LS_WORD       = 3'd4,
    LS_WORD_U     = 3'd5,
    LS_DOUBLEWORD = 3'd6
  } ls_type_t;

  // --------------------
  // Records
  // --------------------

  // Request into an address adder
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    ls_type_t         ls_type;
    // Base register value
    logic [XLEN-1:0]  base;
    // Sign-extended immediate offset
    logic [XLEN-1:0]  offs;
  } adder_req_t;

  // Answer from an address adder
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    // Effective address, wraps modulo 2^XLEN
    logic [XLEN-1:0]  result;
    logic             except_raised;
    // Valid even when except_raised is low
    logic [EXC_W-1:0] except_code;
  } adder_ans_t;

  // Merged output record
  typedef struct packed {
    // Set when the answer comes from the store adder
    logic       is_store;
    adder_ans_t ans;
  } agu_out_t;

endpackage

// ==== hw/agu_top.sv ====
// Address generation stage of the load/store unit
// Two cycles from request to output without contention or back-pressure
// Flush empties every stage and blocks both request ports for that cycle
`timescale 1ns/100ps

module agu_top
  import agu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,

  // Load requests
  input  logic       ld_valid_i,
  output logic       ld_ready_o,
  input  adder_req_t ld_req_i,

  // Store requests
  input  logic       st_valid_i,
  output logic       st_ready_o,
  input  adder_req_t st_req_i,

  // Merged answers
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output agu_out_t   out_o
);

  // --------------------
  // Adder to arbiter
  // --------------------
  logic       ld_ans_valid;
  logic       ld_ans_ready;
  adder_ans_t ld_ans;
  logic       st_ans_valid;
  logic       st_ans_ready;
  adder_ans_t st_ans;

  // Load address adder
  address_adder #(
    .IS_STORE(1'b0)
  ) u_ld_adder (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(ld_valid_i),
    .ready_o(ld_ready_o),
    .req_i  (ld_req_i),
    .valid_o(ld_ans_valid),
    .ready_i(ld_ans_ready),
    .ans_o  (ld_ans)
  );

  // Store address adder
  address_adder #(
    .IS_STORE(1'b1)
  ) u_st_adder (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i(st_valid_i),
    .ready_o(st_ready_o),
    .req_i  (st_req_i),
    .valid_o(st_ans_valid),
    .ready_i(st_ans_ready),
    .ans_o  (st_ans)
  );

  // Merge into one tagged stream
  agu_ans_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .ld_valid_i (ld_ans_valid),
    .ld_ready_o (ld_ans_ready),
    .ld_ans_i   (ld_ans),
    .st_valid_i (st_ans_valid),
    .st_ready_o (st_ans_ready),
    .st_ans_i   (st_ans),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_o      (out_o)
  );

endmodule

// ==== hw/spill_cell_flush.sv ====
// Two-entry skid buffer with valid/ready handshake and flush
// One cycle of latency; full throughput under back-pressure
// Flush drops both entries and holds ready_o low for that cycle
`timescale 1ns/100ps

module spill_cell_flush #(
  parameter type DATA_T = logic [7:0]
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,

  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,

  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  // --------------------
  // Storage
  // --------------------
  logic  main_valid;
  logic  skid_valid;
  DATA_T main_data;
  DATA_T skid_data;

  // Handshake events of this cycle
  logic  push;
  logic  pop;

  // Room for one more entry unless the skid is full
  assign ready_o = ~skid_valid & ~flush_i;
  assign valid_o = main_valid;
  assign data_o  = main_data;

  assign push = valid_i & ready_o;
  assign pop  = main_valid & ready_i;

  // --------------------
  // Valid bits
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (skid_valid) begin
      // Full, so nothing is pushed; skid moves up on a pop
      if (pop) begin
        skid_valid <= 1'b0;
      end
    end else if (push) begin
      // Main stays valid either way; skid fills only if main is stuck
      main_valid <= 1'b1;
      skid_valid <= main_valid & ~pop;
    end else if (pop) begin
      main_valid <= 1'b0;
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (skid_valid) begin
      if (pop) begin
        main_data <= skid_data;
      end
    end else if (push) begin
      if (main_valid && !pop) begin
        skid_data <= data_i;
      end else begin
        main_data <= data_i;
      end
    end
  end

endmodule
